/* common/img_config.svh */
`ifndef IMG_CONFIG_SVH
`define IMG_CONFIG_SVH

// ======================================================================
// Frame layout
// ======================================================================
`define IMG_HEADER_WORDS   8
`define IMG_PIXEL_BITS     12
`define IMG_WORD_BITS      16

// ======================================================================
// Frame buffer and statistics sizes
// ======================================================================
// Kept small so a capture fits in a short simulation
`define IMG_BUF_WORDS      1024
`define IMG_ADDR_BITS      10

`define IMG_STAT_BITS      18
// Top pixel bits judged for highlight or shadow
`define IMG_STAT_TOP_BITS  7

`endif

/* common/img_pkg.sv */
`include "img_config.svh"

package img_pkg;

    // Registered sensor inputs
    typedef struct packed {
        logic                       frame_valid;
        logic                       line_valid;
        logic [`IMG_PIXEL_BITS-1:0] pixel;
    } pixel_bus_t;

    typedef logic [`IMG_WORD_BITS-1:0] img_word_t;

    // One word towards the frame buffer
    typedef struct packed {
        logic      strobe;
        img_word_t word;
    } buf_write_t;

    // Pixel input sequence
    typedef enum logic [2:0] {
        CAP_IDLE,
        CAP_CLEAR,
        CAP_HEADER,
        CAP_WAIT_FRAME_LOW,
        CAP_WAIT_FRAME_HIGH,
        CAP_FRAME,
        CAP_CHECKSUM_LOW,
        CAP_CHECKSUM_HIGH
    } capture_state_t;

endpackage

/* common/ctrl_pkg.sv */
`include "img_config.svh"

package ctrl_pkg;

    // Top level control sequence
    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_CAPTURING,
        CTRL_READING
    } ctrl_state_t;

    // Result of the last capture
    typedef struct packed {
        logic [`IMG_ADDR_BITS:0]   word_count;
        logic [`IMG_STAT_BITS-1:0] highlight_count;
        logic [`IMG_STAT_BITS-1:0] shadow_count;
    } capture_status_t;

endpackage

/* capture/fletcher_checksum.sv */
module fletcher_checksum (
    input  logic               clk,
    input  logic               clear,
    input  logic               enable,
    input  img_pkg::img_word_t word,
    output logic [31:0]        sum
);

    logic [15:0] sum1;
    logic [15:0] sum2;
    logic [15:0] sum1_next;
    logic [15:0] sum2_next;

    // Addition modulo 65535
    function automatic logic [15:0] add_mod(input logic [15:0] a, input logic [15:0] b);
        logic [16:0] total;
        total = a + b;
        if (total >= 17'd65535) total = total - 17'd65535;
        return total[15:0];
    endfunction

    assign sum1_next = add_mod(sum1, word);
    assign sum2_next = add_mod(sum2, sum1_next);
    assign sum       = {sum2, sum1};

    always_ff @(posedge clk) begin
        if (clear) begin
            sum1 <= '0;
            sum2 <= '0;
        end else if (enable) begin
            sum1 <= sum1_next;
            sum2 <= sum2_next;
        end
    end

endmodule

/* capture/pixel_stats.sv */
`include "img_config.svh"

module pixel_stats (
    input  logic                      clk,
    input  logic                      clear,
    input  logic                      active,
    input  img_pkg::pixel_bus_t       pixel,
    output logic [`IMG_STAT_BITS-1:0] highlight_count,
    output logic [`IMG_STAT_BITS-1:0] shadow_count
);

    logic [1:0]                     col;
    logic [1:0]                     row;
    logic                           line_valid_prev;
    logic                           sample;
    logic [`IMG_STAT_TOP_BITS-1:0]  top_bits;

    assign top_bits = pixel.pixel[`IMG_PIXEL_BITS-1 -: `IMG_STAT_TOP_BITS];
    // Top left pixel of each 4x4 tile
    assign sample   = active && pixel.line_valid && (col == 2'd0) && (row == 2'd0);

    always_ff @(posedge clk) begin
        if (clear) begin
            col             <= '0;
            row             <= '0;
            line_valid_prev <= 1'b0;
            highlight_count <= '0;
            shadow_count    <= '0;
        end else begin
            line_valid_prev <= pixel.line_valid;

            if (!pixel.line_valid) col <= '0;
            else                   col <= col + 2'd1;

            // Row steps on the falling edge of line valid
            if (!pixel.frame_valid) begin
                row <= '0;
            end else if (line_valid_prev && !pixel.line_valid) begin
                row <= row + 2'd1;
            end

            if (sample) begin
                if (&top_bits)       highlight_count <= highlight_count + 1'b1;
                else if (~|top_bits) shadow_count    <= shadow_count + 1'b1;
            end
        end
    end

endmodule

/* capture/pixel_capture.sv */
`include "img_config.svh"

module pixel_capture (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        capture_start,
    input  logic [`IMG_HEADER_WORDS*`IMG_WORD_BITS-1:0] cmd_header,
    input  img_pkg::pixel_bus_t                         pixel_in,
    output img_pkg::buf_write_t                         buf_write,
    output logic                                        capture_done,
    output logic [`IMG_STAT_BITS-1:0]                   highlight_count,
    output logic [`IMG_STAT_BITS-1:0]                   shadow_count
);

    localparam int HDR_BITS     = `IMG_HEADER_WORDS * `IMG_WORD_BITS;
    localparam int HDR_CNT_BITS = $clog2(`IMG_HEADER_WORDS);
    localparam int PAD_BITS     = `IMG_WORD_BITS - `IMG_PIXEL_BITS;

    img_pkg::capture_state_t   state;
    img_pkg::pixel_bus_t       pix_reg;
    img_pkg::buf_write_t       next_write;
    logic                      write_strobe;
    img_pkg::img_word_t        write_word;
    logic [HDR_BITS-1:0]       header_shift;
    logic [HDR_CNT_BITS-1:0]   header_left;
    logic                      in_frame;
    logic                      block_clear;
    logic                      csum_enable;
    logic [31:0]               csum;

    assign in_frame    = (state == img_pkg::CAP_WAIT_FRAME_HIGH) ||
                         (state == img_pkg::CAP_FRAME);
    assign block_clear = reset || (state == img_pkg::CAP_CLEAR);

    // ======================================================================
    // Word selection
    // ======================================================================
    always_comb begin
        next_write = '0;
        case (state)
            img_pkg::CAP_HEADER: begin
                next_write.strobe = 1'b1;
                next_write.word   = header_shift[HDR_BITS-1 -: `IMG_WORD_BITS];
            end
            img_pkg::CAP_WAIT_FRAME_HIGH, img_pkg::CAP_FRAME: begin
                next_write.strobe = pix_reg.frame_valid && pix_reg.line_valid;
                next_write.word   = {{PAD_BITS{1'b0}}, pix_reg.pixel};
            end
            img_pkg::CAP_CHECKSUM_LOW: begin
                next_write.strobe = 1'b1;
                next_write.word   = csum[15:0];
            end
            img_pkg::CAP_CHECKSUM_HIGH: begin
                next_write.strobe = 1'b1;
                next_write.word   = csum[31:16];
            end
            default: begin
                next_write = '0;
            end
        endcase
    end

    // The checksum covers header and pixels, not itself
    assign csum_enable = next_write.strobe &&
                         (state != img_pkg::CAP_CHECKSUM_LOW) &&
                         (state != img_pkg::CAP_CHECKSUM_HIGH);

    assign buf_write.strobe = write_strobe;
    assign buf_write.word   = write_word;

    // ======================================================================
    // Capture FSM
    // ======================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= img_pkg::CAP_IDLE;
            pix_reg      <= '0;
            write_strobe <= 1'b0;
            capture_done <= 1'b0;
            header_left  <= '0;
        end else begin
            pix_reg      <= pixel_in;
            write_strobe <= next_write.strobe;
            capture_done <= (state == img_pkg::CAP_CHECKSUM_HIGH);

            case (state)
                img_pkg::CAP_IDLE: begin
                    if (capture_start) state <= img_pkg::CAP_CLEAR;
                end
                img_pkg::CAP_CLEAR: begin
                    header_left <= HDR_CNT_BITS'(`IMG_HEADER_WORDS - 1);
                    state       <= img_pkg::CAP_HEADER;
                end
                img_pkg::CAP_HEADER: begin
                    header_left <= header_left - 1'b1;
                    if (header_left == '0) state <= img_pkg::CAP_WAIT_FRAME_LOW;
                end
                // Skip any frame already running
                img_pkg::CAP_WAIT_FRAME_LOW: begin
                    if (!pix_reg.frame_valid) state <= img_pkg::CAP_WAIT_FRAME_HIGH;
                end
                img_pkg::CAP_WAIT_FRAME_HIGH: begin
                    if (pix_reg.frame_valid) state <= img_pkg::CAP_FRAME;
                end
                img_pkg::CAP_FRAME: begin
                    if (!pix_reg.frame_valid) state <= img_pkg::CAP_CHECKSUM_LOW;
                end
                img_pkg::CAP_CHECKSUM_LOW: begin
                    state <= img_pkg::CAP_CHECKSUM_HIGH;
                end
                default: begin
                    state <= img_pkg::CAP_IDLE;
                end
            endcase
        end
    end

    // Header shifts out MSW first
    always_ff @(posedge clk) begin
        write_word <= next_write.word;
        if (state == img_pkg::CAP_CLEAR) begin
            header_shift <= cmd_header;
        end else if (state == img_pkg::CAP_HEADER) begin
            header_shift <= header_shift << `IMG_WORD_BITS;
        end
    end

    fletcher_checksum u_checksum (
        .clk    (clk),
        .clear  (block_clear),
        .enable (csum_enable),
        .word   (next_write.word),
        .sum    (csum)
    );

    pixel_stats u_stats (
        .clk             (clk),
        .clear           (block_clear),
        .active          (in_frame),
        .pixel           (pix_reg),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count)
    );

endmodule

/* src/frame_buffer.sv */
`include "img_config.svh"

module frame_buffer (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    capture_start,
    input  logic                    readout_start,
    input  img_pkg::buf_write_t     buf_write,
    input  logic                    readout_trigger,
    output logic                    readout_ready,
    output logic                    readout_valid,
    output logic                    readout_end,
    output img_pkg::img_word_t      readout_data,
    output logic [`IMG_ADDR_BITS:0] word_count
);

    localparam logic [`IMG_ADDR_BITS:0] BUF_DEPTH = `IMG_BUF_WORDS;

    img_pkg::img_word_t        mem [`IMG_BUF_WORDS];
    logic [`IMG_ADDR_BITS-1:0] wr_ptr;
    logic [`IMG_ADDR_BITS:0]   rd_ptr;
    logic                      write_en;
    logic                      read_en;
    logic                      last_read;

    // Writes past the end of the buffer are dropped
    assign write_en  = buf_write.strobe && (word_count != BUF_DEPTH);
    assign read_en   = readout_trigger && readout_ready;
    assign last_read = ((rd_ptr + 1'b1) == word_count);

    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[wr_ptr] <= buf_write.word;
        end
        if (read_en) begin
            readout_data <= mem[rd_ptr[`IMG_ADDR_BITS-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr        <= '0;
            word_count    <= '0;
            rd_ptr        <= '0;
            readout_ready <= 1'b0;
            readout_valid <= 1'b0;
            readout_end   <= 1'b0;
        end else begin
            readout_valid <= read_en;
            readout_end   <= 1'b0;

            if (capture_start) begin
                wr_ptr     <= '0;
                word_count <= '0;
            end else if (write_en) begin
                wr_ptr     <= wr_ptr + 1'b1;
                word_count <= word_count + 1'b1;
            end

            if (readout_start) begin
                rd_ptr        <= '0;
                readout_ready <= (word_count != '0);
                // Nothing stored, finish at once
                readout_end   <= (word_count == '0);
            end else if (read_en) begin
                rd_ptr <= rd_ptr + 1'b1;
                if (last_read) begin
                    readout_ready <= 1'b0;
                    readout_end   <= 1'b1;
                end
            end
        end
    end

endmodule

/* src/capture_sequencer.sv */
module capture_sequencer (
    input  logic clk,
    input  logic reset,
    input  logic cmd_capture,
    input  logic cmd_readout,
    input  logic capture_done,
    input  logic readout_end,
    output logic capture_start,
    output logic readout_start,
    output logic status_capture_done,
    output logic status_busy
);

    ctrl_pkg::ctrl_state_t state;

    assign status_busy = (state != ctrl_pkg::CTRL_IDLE);

    // Commands are only taken in idle, anything else is dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            state               <= ctrl_pkg::CTRL_IDLE;
            capture_start       <= 1'b0;
            readout_start       <= 1'b0;
            status_capture_done <= 1'b0;
        end else begin
            capture_start       <= 1'b0;
            readout_start       <= 1'b0;
            status_capture_done <= 1'b0;

            case (state)
                ctrl_pkg::CTRL_IDLE: begin
                    // Capture wins if both arrive together
                    if (cmd_capture) begin
                        capture_start <= 1'b1;
                        state         <= ctrl_pkg::CTRL_CAPTURING;
                    end else if (cmd_readout) begin
                        readout_start <= 1'b1;
                        state         <= ctrl_pkg::CTRL_READING;
                    end
                end

                ctrl_pkg::CTRL_CAPTURING: begin
                    if (capture_done) begin
                        status_capture_done <= 1'b1;
                        state               <= ctrl_pkg::CTRL_IDLE;
                    end
                end

                ctrl_pkg::CTRL_READING: begin
                    // Buffer signals the last word or an empty buffer
                    if (readout_end) begin
                        state <= ctrl_pkg::CTRL_IDLE;
                    end
                end

                default: begin
                    state <= ctrl_pkg::CTRL_IDLE;
                end
            endcase
        end
    end

endmodule

/* src/img_controller.sv */
`include "img_config.svh"

module img_controller (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          cmd_capture,
    input  logic                                          cmd_readout,
    input  logic [`IMG_HEADER_WORDS*`IMG_WORD_BITS-1:0]   cmd_header,
    input  img_pkg::pixel_bus_t                           pixel_in,
    input  logic                                          readout_trigger,
    output logic                                          readout_ready,
    output logic                                          readout_valid,
    output img_pkg::img_word_t                            readout_data,
    output logic                                          status_capture_done,
    output logic                                          status_busy,
    output ctrl_pkg::capture_status_t                     status
);

    logic                       capture_start;
    logic                       readout_start;
    logic                       capture_done;
    logic                       readout_end;
    img_pkg::buf_write_t        buf_write;
    logic [`IMG_ADDR_BITS:0]    word_count;
    logic [`IMG_STAT_BITS-1:0]  highlight_count;
    logic [`IMG_STAT_BITS-1:0]  shadow_count;

    // ======================================================================
    // Control
    // ======================================================================
    capture_sequencer u_sequencer (
        .clk                 (clk),
        .reset               (reset),
        .cmd_capture         (cmd_capture),
        .cmd_readout         (cmd_readout),
        .capture_done        (capture_done),
        .readout_end         (readout_end),
        .capture_start       (capture_start),
        .readout_start       (readout_start),
        .status_capture_done (status_capture_done),
        .status_busy         (status_busy)
    );

    // ======================================================================
    // Datapath
    // ======================================================================
    pixel_capture u_capture (
        .clk             (clk),
        .reset           (reset),
        .capture_start   (capture_start),
        .cmd_header      (cmd_header),
        .pixel_in        (pixel_in),
        .buf_write       (buf_write),
        .capture_done    (capture_done),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count)
    );

    frame_buffer u_buffer (
        .clk             (clk),
        .reset           (reset),
        .capture_start   (capture_start),
        .readout_start   (readout_start),
        .buf_write       (buf_write),
        .readout_trigger (readout_trigger),
        .readout_ready   (readout_ready),
        .readout_valid   (readout_valid),
        .readout_end     (readout_end),
        .readout_data    (readout_data),
        .word_count      (word_count)
    );

    assign status.word_count      = word_count;
    assign status.highlight_count = highlight_count;
    assign status.shadow_count    = shadow_count;

endmodule

/* sim/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 100ps;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset held for 8 rising edges, released just after the last one
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

/* sim/tb_checker.sv */
module tb_checker (
    input logic                      clk,
    input logic                      reset,
    input logic                      readout_ready,
    input logic                      readout_valid,
    input img_pkg::img_word_t        readout_data,
    input logic                      status_capture_done,
    input logic                      status_busy,
    input ctrl_pkg::capture_status_t status
);

    timeunit 1ns;
    timeprecision 100ps;

    img_pkg::img_word_t expected_q [$];
    int                 exp_word_count = 0;
    int                 exp_highlights = 0;
    int                 exp_shadows    = 0;
    logic               status_armed   = 1'b0;
    int                 mismatches     = 0;
    int                 failures       = 0;

    // ======================================================================
    // Expectations loaded by the stimulus
    // ======================================================================
    task automatic expect_word(input img_pkg::img_word_t word);
        expected_q.push_back(word);
    endtask

    task automatic expect_status(input int words, input int highlights, input int shadows);
        exp_word_count = words;
        exp_highlights = highlights;
        exp_shadows    = shadows;
        status_armed   = 1'b1;
    endtask

    task automatic check_drained();
        if (expected_q.size() != 0) begin
            failures++;
            $display("Error at %0t: %0d readout words never arrived", $time, expected_q.size());
        end
    endtask

    task automatic compare_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            mismatches++;
            $display("Fail at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    // ======================================================================
    // Monitor, sampled mid cycle
    // ======================================================================
    always @(negedge clk) begin
        if (!reset) begin
            if (readout_valid) begin
                if (expected_q.size() == 0) begin
                    failures++;
                    $display("Error at %0t: readout word %h arrived when none was expected",
                             $time, readout_data);
                end else begin
                    compare_value("readout_data", int'(expected_q.pop_front()),
                                  int'(readout_data));
                end
            end

            // Ready with nothing queued means a readout started that should not have
            if (readout_ready && expected_q.size() == 0) begin
                failures++;
                $display("Error at %0t: readout_ready high with no readout pending", $time);
            end

            // A readout in progress keeps the controller busy
            if (readout_ready && !status_busy) begin
                failures++;
                $display("Error at %0t: readout_ready high while status_busy is low",
                         $time);
            end

            if (status_capture_done) begin
                if (!status_armed) begin
                    failures++;
                    $display("Error at %0t: capture finished with no capture running", $time);
                end else begin
                    compare_value("status.word_count", exp_word_count,
                                  int'(status.word_count));
                    compare_value("status.highlight_count", exp_highlights,
                                  int'(status.highlight_count));
                    compare_value("status.shadow_count", exp_shadows,
                                  int'(status.shadow_count));
                    status_armed = 1'b0;
                end
            end
        end
    end

    // Outputs just after reset
    initial begin
        @(negedge reset);
        @(negedge clk);
        if (readout_ready || readout_valid || status_capture_done || status_busy) begin
            failures++;
            $display("Error at %0t: a strobe or level is still high after reset", $time);
        end
        compare_value("status.word_count", 0, int'(status.word_count));
        compare_value("status.highlight_count", 0, int'(status.highlight_count));
        compare_value("status.shadow_count", 0, int'(status.shadow_count));
    end

endmodule

/* sim/img_controller_asserts.sv */
module img_controller_asserts (
    input logic                clk,
    input logic                reset,
    input logic                readout_trigger,
    input logic                readout_ready,
    input logic                readout_valid,
    input logic                capture_start,
    input logic                status_capture_done,
    input img_pkg::buf_write_t buf_write
);

    timeunit 1ns;
    timeprecision 100ps;

    // Each word answers a trigger taken one cycle before
    valid_after_trigger: assert property (@(posedge clk) disable iff (reset)
        readout_valid |-> $past(readout_trigger && readout_ready))
    else $error("readout_valid without an accepted trigger one cycle before");

    // Clear takes one cycle, the header register adds one more
    header_after_start: assert property (@(posedge clk) disable iff (reset)
        capture_start |-> ##3 buf_write.strobe [*8])
    else $error("capture_start not followed by eight header writes");

    done_not_in_readout: assert property (@(posedge clk) disable iff (reset)
        status_capture_done |-> !readout_ready)
    else $error("status_capture_done while readout_ready is high");

endmodule

/* sim/tb_img_controller.sv */
`include "img_config.svh"

module tb_img_controller;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HDR_BITS  = `IMG_HEADER_WORDS * `IMG_WORD_BITS;
    localparam int LINE_GAP  = 3;
    localparam int LINES_A   = 10;
    localparam int PIXELS_A  = 12;
    localparam int LINES_B   = 8;
    localparam int PIXELS_B  = 20;
    // Partial frame, gaps and both captured frames
    localparam int STIM_CYCLES = 4 * (PIXELS_A + LINE_GAP) + 6 + LINE_GAP +
                                 LINES_A * (PIXELS_A + LINE_GAP) + 16 + LINE_GAP +
                                 LINES_B * (PIXELS_B + LINE_GAP);
    localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES + 2000;

    logic                      clk;
    logic                      reset;
    logic                      cmd_capture;
    logic                      cmd_readout;
    logic [HDR_BITS-1:0]       cmd_header;
    img_pkg::pixel_bus_t       pixel_in;
    logic                      readout_trigger;
    logic                      readout_ready;
    logic                      readout_valid;
    img_pkg::img_word_t        readout_data;
    logic                      status_capture_done;
    logic                      status_busy;
    ctrl_pkg::capture_status_t status;

    logic [`IMG_PIXEL_BITS-1:0] pixels [$];
    img_pkg::img_word_t         exp_words [$];
    int                         cycles = 0;

    tb_clock_gen u_clock (
        .clk   (clk),
        .reset (reset)
    );

    img_controller UUT (
        .clk                 (clk),
        .reset               (reset),
        .cmd_capture         (cmd_capture),
        .cmd_readout         (cmd_readout),
        .cmd_header          (cmd_header),
        .pixel_in            (pixel_in),
        .readout_trigger     (readout_trigger),
        .readout_ready       (readout_ready),
        .readout_valid       (readout_valid),
        .readout_data        (readout_data),
        .status_capture_done (status_capture_done),
        .status_busy         (status_busy),
        .status              (status)
    );

    tb_checker u_checker (
        .clk                 (clk),
        .reset               (reset),
        .readout_ready       (readout_ready),
        .readout_valid       (readout_valid),
        .readout_data        (readout_data),
        .status_capture_done (status_capture_done),
        .status_busy         (status_busy),
        .status              (status)
    );

    bind img_controller img_controller_asserts u_asserts (
        .clk                 (clk),
        .reset               (reset),
        .readout_trigger     (readout_trigger),
        .readout_ready       (readout_ready),
        .readout_valid       (readout_valid),
        .capture_start       (capture_start),
        .status_capture_done (status_capture_done),
        .buf_write           (buf_write)
    );

    // ======================================================================
    // Reference model
    // ======================================================================
    // Header MSW first, pixels zero extended, then Fletcher-32 low and high
    function automatic void expected_words(input logic [HDR_BITS-1:0] header);
        int                 sum1;
        int                 sum2;
        img_pkg::img_word_t word;
        sum1 = 0;
        sum2 = 0;
        exp_words.delete();
        for (int i = 0; i < `IMG_HEADER_WORDS + pixels.size(); i++) begin
            if (i < `IMG_HEADER_WORDS) word = header[HDR_BITS-1-16*i -: 16];
            else word = {4'h0, pixels[i-`IMG_HEADER_WORDS]};
            exp_words.push_back(word);
            sum1 = (sum1 + int'(word)) % 65535;
            sum2 = (sum2 + sum1) % 65535;
        end
        exp_words.push_back(16'(sum1));
        exp_words.push_back(16'(sum2));
    endfunction

    // Samples at column and row 0 modulo 4
    function automatic int count_samples(input int ppl, input bit highlight);
        int                            total;
        logic [`IMG_STAT_TOP_BITS-1:0] top;
        total = 0;
        foreach (pixels[i]) begin
            top = pixels[i][`IMG_PIXEL_BITS-1 -: `IMG_STAT_TOP_BITS];
            if (((i / ppl) % 4 == 0) && ((i % ppl) % 4 == 0)) begin
                if (highlight && (&top)) total++;
                else if (!highlight && (top == '0)) total++;
            end
        end
        return total;
    endfunction

    // Random pixel, often forced bright or dark where it will be sampled
    function automatic logic [`IMG_PIXEL_BITS-1:0] make_pixel(input int line, input int col);
        logic [`IMG_PIXEL_BITS-1:0] value;
        value = `IMG_PIXEL_BITS'($urandom);
        if ((line % 4 == 0) && (col % 4 == 0)) begin
            case ($urandom % 3)
                0: value[`IMG_PIXEL_BITS-1 -: `IMG_STAT_TOP_BITS] = '1;
                1: value[`IMG_PIXEL_BITS-1 -: `IMG_STAT_TOP_BITS] = '0;
                default: ;
            endcase
        end
        return value;
    endfunction

    // ======================================================================
    // Stimulus tasks
    // ======================================================================
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_lines(input int lines, input int ppl, input bit keep);
        logic [`IMG_PIXEL_BITS-1:0] value;
        for (int l = 0; l < lines; l++) begin
            for (int c = 0; c < ppl; c++) begin
                value = make_pixel(l, c);
                if (keep) pixels.push_back(value);
                pixel_in.line_valid = 1'b1;
                pixel_in.pixel      = value;
                next_cycle();
            end
            pixel_in.line_valid = 1'b0;
            pixel_in.pixel      = '0;
            repeat (LINE_GAP) next_cycle();
        end
    endtask

    task automatic run_capture(input logic [HDR_BITS-1:0] header, input int lines,
                               input int ppl, input bit partial);
        cmd_header = header;
        pixels.delete();
        if (partial) begin
            pixel_in.frame_valid = 1'b1;
            drive_lines(1, ppl, 1'b0);
        end
        cmd_capture = 1'b1;
        next_cycle();
        cmd_capture = 1'b0;
        if (partial) begin
            // Readout request once the header is stored, to be dropped
            drive_lines(1, ppl, 1'b0);
            cmd_readout = 1'b1;
            next_cycle();
            cmd_readout = 1'b0;
            drive_lines(2, ppl, 1'b0);
            pixel_in.frame_valid = 1'b0;
            repeat (4) next_cycle();
        end else begin
            // Header takes ten cycles before the frame is watched
            repeat (16) next_cycle();
        end
        pixel_in.frame_valid = 1'b1;
        repeat (LINE_GAP) next_cycle();
        drive_lines(lines, ppl, 1'b1);
        pixel_in.frame_valid = 1'b0;

        expected_words(header);
        foreach (exp_words[i]) u_checker.expect_word(exp_words[i]);
        u_checker.expect_status(exp_words.size(), count_samples(ppl, 1'b1),
                                count_samples(ppl, 1'b0));
        while (!status_capture_done) next_cycle();
        next_cycle();
    endtask

    task automatic do_readout();
        cmd_readout = 1'b1;
        next_cycle();
        cmd_readout = 1'b0;
        while (!readout_ready) next_cycle();
        while (readout_ready) begin
            readout_trigger = ($urandom % 4 != 0);
            next_cycle();
        end
        readout_trigger = 1'b0;
        while (status_busy) next_cycle();
        // One more trigger with the buffer drained
        readout_trigger = 1'b1;
        next_cycle();
        readout_trigger = 1'b0;
        repeat (4) next_cycle();
        u_checker.check_drained();
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        int seed_ret;
        int errors;
        cmd_capture     = 1'b0;
        cmd_readout     = 1'b0;
        cmd_header      = '0;
        pixel_in        = '0;
        readout_trigger = 1'b0;
        seed_ret        = $urandom(87176);

        @(negedge reset);
        repeat (2) next_cycle();

        run_capture({$urandom, $urandom, $urandom, $urandom}, LINES_A, PIXELS_A, 1'b1);
        do_readout();
        // Second capture must replace words and counts
        run_capture({$urandom, $urandom, $urandom, $urandom}, LINES_B, PIXELS_B, 1'b0);
        do_readout();
        repeat (5) next_cycle();

        errors = u_checker.mismatches + u_checker.failures;
        $display("Errors: %0d value mismatches, %0d other failures, %0d total",
                 u_checker.mismatches, u_checker.failures, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

endmodule

/* all.f */
+incdir+common
common/img_pkg.sv
common/ctrl_pkg.sv
capture/fletcher_checksum.sv
capture/pixel_stats.sv
capture/pixel_capture.sv
src/frame_buffer.sv
src/capture_sequencer.sv
src/img_controller.sv
sim/tb_clock_gen.sv
sim/tb_checker.sv
sim/img_controller_asserts.sv
sim/tb_img_controller.sv
